//--- source/rv_core_pkg.sv
package rv_core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // FIFO depths and initial credit counts
    localparam int IN_DEPTH    = 4;
    localparam int OUT_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;

    // Supported major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef logic [XLEN-1:0] insn_t;

    // Decode to execute record
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic                  opb_imm;
        logic                  lui;
        alu_op_e               alu_op;
    } dec_t;

    // One result record per retired instruction
    typedef struct packed {
        logic                  illegal;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } res_t;

    // Execute to result payload, also the forwarding source
    typedef struct packed {
        logic valid;
        res_t res;
    } exr_t;

endpackage

//--- source/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = rv_core_pkg::insn_t
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  payload_t push_data_i,
    output logic     pop_valid_o,
    output payload_t pop_data_o,
    output logic     credit_o,
    input  logic     down_credit_i
);

    // An instruction-wide payload marks the input side of the core
    localparam bit IS_INSN      = ($bits(payload_t) == rv_core_pkg::XLEN);
    localparam int DEPTH        = IS_INSN ? rv_core_pkg::IN_DEPTH : rv_core_pkg::OUT_DEPTH;
    localparam int INIT_CREDITS = IS_INSN ? rv_core_pkg::OUT_DEPTH : rv_core_pkg::OUT_CREDITS;
    localparam int PTR_W        = $clog2(DEPTH);
    localparam int CNT_W        = $clog2(DEPTH + 1);
    localparam int CRED_W       = $clog2(INIT_CREDITS + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [CRED_W-1:0] credit_q;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Pop needs an entry and a downstream credit
    assign pop         = (count_q != '0) && (credit_q != '0);
    assign pop_valid_o = pop;
    assign pop_data_o  = mem[rd_ptr_q];
    assign credit_o    = pop;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= CRED_W'(INIT_CREDITS);
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop);
            // Spent on pop, returned by the consumer side
            credit_q <= credit_q + CRED_W'(down_credit_i) - CRED_W'(pop);
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               insn_valid_i,
    input  rv_core_pkg::insn_t                 insn_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data_i,
    output rv_core_pkg::dec_t                  dec_o
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::dec_t    dec_d;
    rv_core_pkg::dec_t    dec_q;
    logic                 valid_q;

    assign opcode     = insn_i[6:0];
    assign funct3     = insn_i[14:12];
    assign rs1_addr_o = insn_i[19:15];
    assign rs2_addr_o = insn_i[24:20];

    // Bit 30 selects SUB only in register form, SRA in both forms
    always_comb begin
        unique case (funct3)
            3'b000: begin
                alu_op = (insn_i[30] && (opcode == rv_core_pkg::OPC_OP)) ?
                         rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            end
            3'b001: alu_op = rv_core_pkg::ALU_SLL;
            3'b010: alu_op = rv_core_pkg::ALU_SLT;
            3'b011: alu_op = rv_core_pkg::ALU_SLTU;
            3'b100: alu_op = rv_core_pkg::ALU_XOR;
            3'b101: alu_op = insn_i[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110: alu_op = rv_core_pkg::ALU_OR;
            default: alu_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = insn_valid_i;
        dec_d.rd       = insn_i[11:7];
        dec_d.rs1      = rs1_addr_o;
        dec_d.rs2      = rs2_addr_o;
        dec_d.rs1_data = rs1_data_i;
        dec_d.rs2_data = rs2_data_i;
        dec_d.alu_op   = alu_op;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                dec_d.we = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                dec_d.we      = 1'b1;
                dec_d.opb_imm = 1'b1;
                dec_d.imm     = {{20{insn_i[31]}}, insn_i[31:20]};
            end
            rv_core_pkg::OPC_LUI: begin
                dec_d.we     = 1'b1;
                dec_d.lui    = 1'b1;
                dec_d.imm    = {insn_i[31:12], 12'b0};
                dec_d.alu_op = rv_core_pkg::ALU_PASS_B;
            end
            default: begin
                // Unknown opcode returns zero data and no write
                dec_d.illegal = 1'b1;
                dec_d.opb_imm = 1'b1;
                dec_d.alu_op  = rv_core_pkg::ALU_PASS_B;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= insn_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_q <= dec_d;
    end

    always_comb begin
        dec_o       = dec_q;
        dec_o.valid = valid_q;
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               wr_en_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]       wr_data_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data_o
);

    // x0 has no storage
    logic [rv_core_pkg::XLEN-1:0] regs [1:31];

    function automatic logic [rv_core_pkg::XLEN-1:0] read_port(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        // Write-through so the issuing word sees this cycle's write
        if (wr_en_i && (wr_addr_i == addr)) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_core_pkg::dec_t dec_i,
    input  rv_core_pkg::exr_t res_fwd_i,
    output rv_core_pkg::exr_t exr_o
);

    logic [rv_core_pkg::XLEN-1:0] rs1_fwd;
    logic [rv_core_pkg::XLEN-1:0] rs2_fwd;
    logic [rv_core_pkg::XLEN-1:0] op_a;
    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [rv_core_pkg::XLEN-1:0] alu_res;
    rv_core_pkg::exr_t            exr_d;
    rv_core_pkg::res_t            res_q;
    logic                         valid_q;

    // A stage only forwards a live, nonzero register write
    function automatic logic fwd_hit(
        input rv_core_pkg::exr_t                  src,
        input logic [rv_core_pkg::REG_ADDR_W-1:0] idx
    );
        return src.valid && src.res.we && (src.res.rd != '0) && (src.res.rd == idx);
    endfunction

    // Youngest producer first
    always_comb begin
        if (fwd_hit(exr_o, dec_i.rs1)) begin
            rs1_fwd = exr_o.res.data;
        end else if (fwd_hit(res_fwd_i, dec_i.rs1)) begin
            rs1_fwd = res_fwd_i.res.data;
        end else begin
            rs1_fwd = dec_i.rs1_data;
        end

        if (fwd_hit(exr_o, dec_i.rs2)) begin
            rs2_fwd = exr_o.res.data;
        end else if (fwd_hit(res_fwd_i, dec_i.rs2)) begin
            rs2_fwd = res_fwd_i.res.data;
        end else begin
            rs2_fwd = dec_i.rs2_data;
        end
    end

    assign op_a = rs1_fwd;
    assign op_b = (dec_i.opb_imm || dec_i.lui) ? dec_i.imm : rs2_fwd;

    always_comb begin
        case (dec_i.alu_op)
            rv_core_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_core_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_core_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_core_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
            rv_core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
            rv_core_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            rv_core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            rv_core_pkg::ALU_PASS_B: alu_res = op_b;
            default:                 alu_res = '0;
        endcase
    end

    always_comb begin
        exr_d.valid       = dec_i.valid;
        exr_d.res.illegal = dec_i.illegal;
        exr_d.res.we      = dec_i.we;
        exr_d.res.rd      = dec_i.rd;
        exr_d.res.data    = alu_res;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exr_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_q <= exr_d.res;
    end

    assign exr_o = {valid_q, res_q};

endmodule

//--- source/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  rv_core_pkg::exr_t exr_i,
    output rv_core_pkg::exr_t exr_o,
    output logic              push_o,
    output rv_core_pkg::res_t res_o
);

    logic              valid_q;
    rv_core_pkg::res_t res_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exr_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_q <= exr_i.res;
    end

    // Older forwarding source and write-back port
    assign exr_o = {valid_q, res_q};

    // Every live instruction yields one record, bubbles none
    assign push_o = valid_q;
    assign res_o  = res_q;

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               insn_valid_i,
    input  rv_core_pkg::insn_t insn_i,
    output logic               insn_credit_o,
    output logic               res_valid_o,
    output rv_core_pkg::res_t  res_o,
    input  logic               res_credit_i
);

    logic                               issue_valid;
    rv_core_pkg::insn_t                 issue_insn;
    logic                               out_pop;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;
    rv_core_pkg::dec_t                  dec;
    rv_core_pkg::exr_t                  exr;
    rv_core_pkg::exr_t                  wb;
    logic                               res_push;
    rv_core_pkg::res_t                  res_rec;

    // Input side, issue credits come back as results leave
    credit_fifo #(
        .payload_t (rv_core_pkg::insn_t)
    ) u_in_fifo (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (insn_valid_i),
        .push_data_i   (insn_i),
        .pop_valid_o   (issue_valid),
        .pop_data_o    (issue_insn),
        .credit_o      (insn_credit_o),
        .down_credit_i (out_pop)
    );

    decode_stage u_decode (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .insn_valid_i (issue_valid),
        .insn_i       (issue_insn),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .dec_o        (dec)
    );

    register_file u_regfile (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_en_i    (wb.valid & wb.res.we),
        .wr_addr_i  (wb.res.rd),
        .wr_data_i  (wb.res.data),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_stage u_execute (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .dec_i     (dec),
        .res_fwd_i (wb),
        .exr_o     (exr)
    );

    result_stage u_result (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .exr_i  (exr),
        .exr_o  (wb),
        .push_o (res_push),
        .res_o  (res_rec)
    );

    // Output side, gated by the consumer's buffer credits
    credit_fifo #(
        .payload_t (rv_core_pkg::res_t)
    ) u_out_fifo (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (res_push),
        .push_data_i   (res_rec),
        .pop_valid_o   (res_valid_o),
        .pop_data_o    (res_o),
        .credit_o      (out_pop),
        .down_credit_i (res_credit_i)
    );

endmodule

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int MAX_CASES  = 64;
    // Consumer returns no credits inside this cycle window
    localparam int HOLD_START = 15;
    localparam int HOLD_END   = 45;

    logic               clk;
    logic               rst_n;
    logic               insn_valid;
    rv_core_pkg::insn_t insn;
    logic               insn_credit;
    logic               res_valid;
    rv_core_pkg::res_t  res;
    logic               res_credit;

    // Four words per case: insn, rd, data, illegal
    logic [31:0] case_mem [0:4*MAX_CASES-1];
    int          n_cases;
    int          errors;
    int          cycle;
    int          limit;
    int          sent;
    int          recv;
    int          prod_credits;
    int          credits_seen;
    int          returned;
    int          credit_due[$];
    integer      seed;

    rv_core_top UUT (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .insn_valid_i  (insn_valid),
        .insn_i        (insn),
        .insn_credit_o (insn_credit),
        .res_valid_o   (res_valid),
        .res_o         (res),
        .res_credit_i  (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    initial begin
        int delay;
        rst_n        = 1'b0;
        insn_valid   = 1'b0;
        insn         = '0;
        res_credit   = 1'b0;
        seed         = 6132;
        errors       = 0;
        cycle        = 0;
        sent         = 0;
        recv         = 0;
        prod_credits = rv_core_pkg::IN_DEPTH;
        credits_seen = 0;
        returned     = 0;

        // Entries past the last line keep an illegal column above one
        for (int i = 0; i < 4*MAX_CASES; i++) begin
            case_mem[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh("verification/rv_core_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[4*n_cases+3] <= 32'd1) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            errors++;
            $display("No test cases were read from the case file");
        end
        limit = 20*n_cases + 100;

        repeat (4) begin
            @(negedge clk);
            check_value("reset res_valid_o", 32'd0, 32'(res_valid));
            check_value("reset insn_credit_o", 32'd0, 32'(insn_credit));
        end
        rst_n = 1'b1;

        while (recv < n_cases && cycle < limit) begin
            @(negedge clk);
            cycle++;
            if (cycle == 1) begin
                check_value("post-reset res_valid_o", 32'd0, 32'(res_valid));
                check_value("post-reset insn_credit_o", 32'd0, 32'(insn_credit));
            end

            if (insn_credit) begin
                credits_seen++;
                prod_credits++;
                if (credits_seen > sent) begin
                    errors++;
                    $display("Input returned %0d credits but only %0d words were sent",
                             credits_seen, sent);
                end
            end

            if (res_valid) begin
                if (recv + 1 > returned + rv_core_pkg::OUT_CREDITS) begin
                    errors++;
                    $display("Result %0d delivered without a result credit", recv);
                end
                check_value($sformatf("case %0d rd", recv), case_mem[4*recv+1], 32'(res.rd));
                check_value($sformatf("case %0d data", recv), case_mem[4*recv+2], res.data);
                check_value($sformatf("case %0d illegal", recv), case_mem[4*recv+3],
                            32'(res.illegal));
                check_value($sformatf("case %0d we", recv),
                            (case_mem[4*recv+3] == 32'd0) ? 32'd1 : 32'd0, 32'(res.we));
                recv++;
                delay = int'($unsigned($random(seed)) % 4);
                credit_due.push_back(cycle + delay);
            end

            // At most one credit per cycle
            res_credit = 1'b0;
            if ((cycle < HOLD_START || cycle >= HOLD_END) && credit_due.size() > 0) begin
                if (credit_due[0] <= cycle) begin
                    void'(credit_due.pop_front());
                    res_credit = 1'b1;
                    returned++;
                end
            end

            if (prod_credits > 0 && sent < n_cases) begin
                insn_valid = 1'b1;
                insn       = case_mem[4*sent];
                sent++;
                prod_credits--;
            end else begin
                insn_valid = 1'b0;
                insn       = '0;
            end
        end

        if (recv < n_cases) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycle, recv, n_cases);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verification/rv_core_cases.txt
// insn     rd  data      illegal
// one instruction per line, results expected in this order
06400093 01 00000064 0
FF900113 02 FFFFFFF9 0
002081B3 03 0000005D 0
40208233 04 0000006B 0
0020F2B3 05 00000060 0
0020E333 06 FFFFFFFD 0
0020C3B3 07 FFFFFF9D 0
00300413 08 00000003 0
008094B3 09 00000320 0
00815533 0A 1FFFFFFF 0
408155B3 0B FFFFFFFF 0
00112633 0C 00000001 0
001136B3 0D 00000000 0
0020A733 0E 00000000 0
FFF0C793 0F FFFFFF9B 0
0F017813 10 000000F0 0
80006893 11 FFFFF800 0
FFA12913 12 00000001 0
FFF0B993 13 00000001 0
00409A13 14 00000640 0
4048DA93 15 FFFFFF80 0
0048DB13 16 0FFFFF80 0
12345BB7 17 12345000 0
FFFFFC37 18 FFFFF000 0
678B8C93 19 12345678 0
001C8C93 19 12345679 0
019C8CB3 19 2468ACF2 0
00500D13 1A 00000005 0
00900D93 1B 00000009 0
41AD8E33 1C 00000004 0
03708013 00 0000009B 0
00000EB3 1D 00000000 0
000000EF 01 00000000 1
00008F33 1E 00000064 0
401F0FB3 1F 00000000 0
00000000 00 00000000 1
009181B3 03 0000037D 0

//--- all.f
source/rv_core_pkg.sv
source/credit_fifo.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/result_stage.sv
source/rv_core_top.sv
verification/rv_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

echo "$out" | grep -q '\*\*\* PASSED \*\*\*'
